// File: rtl/archie_pkg.sv
package archie_pkg;

	// clock enable divider, 40 MHz system clock
	localparam int CLKEN_PERIOD = 20;
	localparam int CLK8M_STEP   = 5;
	localparam int CLKEN_CNT_W  = $clog2(CLKEN_PERIOD);
	localparam int CLK8M_CNT_W  = $clog2(CLK8M_STEP);

	// video base clock select codes, 2'b11 behaves like 24 MHz
	localparam logic [1:0] PIX_SEL_24    = 2'b00;
	localparam logic [1:0] PIX_SEL_25    = 2'b01;
	localparam logic [1:0] PIX_SEL_36    = 2'b10;
	localparam logic [1:0] PIX_SEL_RESET = PIX_SEL_36;

	// pll reconfiguration sequencer
	localparam int         RCFG_TMO_W       = 10;
	localparam logic [9:0] RECONFIG_TIMEOUT = 10'd1000;
	localparam logic [1:0] RCFG_IDLE        = 2'b00;
	localparam logic [1:0] RCFG_SETTLE      = 2'b01;
	localparam logic [1:0] RCFG_START       = 2'b10;
	localparam logic [1:0] RCFG_WAIT        = 2'b11;

	// back porch window, counted in clk_sys cycles after hsync
	localparam int PORCH_TV    = 256;
	localparam int PORCH_VGA   = 64;
	localparam int PORCH_CNT_W = 8;
	localparam int PORCH_VGA_W = $clog2(PORCH_VGA);

	localparam int COLOR_W = 4;

	// download indices that land in ram
	localparam logic [7:0] LOADER_ROM_IDX1 = 8'd1;
	localparam logic [7:0] LOADER_ROM_IDX2 = 8'd2;

	localparam int RAM_ADDR_W    = 26;
	localparam int LOADER_ADDR_W = 24;

	typedef struct packed {
		logic [COLOR_W-1:0] red;
		logic [COLOR_W-1:0] green;
		logic [COLOR_W-1:0] blue;
		logic               hsync;
		logic               vsync;
	} video_px_t;

	typedef struct packed {
		logic [RAM_ADDR_W-1:0] adr;
		logic [31:0]           dat;
		logic [3:0]            sel;
		logic                  we;
		logic                  stb;
		logic                  cyc;
	} wb_req_t;

	typedef struct packed {
		logic                     downloading;
		logic [7:0]               index;
		logic                     wr;
		logic [LOADER_ADDR_W-1:0] addr;
		logic [7:0]               data;
	} loader_wr_t;

endpackage

// File: rtl/archie_support_top.sv
`timescale 1ns/1ps

module archie_support_top import archie_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n_i,

	output logic       clk2m_en_o,
	output logic       clk8m_en_o,

	input  logic [1:0] pix_sel_i,
	input  logic       pll_busy_i,
	input  logic [2:0] pll_rom_bits_i,
	output logic       pll_rom_q_o,
	output logic       write_from_rom_o,
	output logic       reconfig_o,
	output logic       reconfig_reset_o,
	output logic       vid_clk_ena_o,

	input  logic       ce_pix_i,
	input  logic       scandoubler_disable_i,
	input  video_px_t  video_i,
	output video_px_t  video_o,
	output logic       scandoubler_en_o,

	input  loader_wr_t loader_i,
	input  wb_req_t    core_req_i,
	output logic       core_ack_o,
	output wb_req_t    ram_req_o,
	input  logic       ram_ack_i,
	input  logic       ram_ready_i,
	input  logic       reset_button_i,
	output logic       rom_ready_o,
	output logic       core_reset_o
);

	clk_enable_gen clk_enable_gen_i (
		.clk_sys    (clk_sys),
		.arst_n_i   (arst_n_i),
		.clk2m_en_o (clk2m_en_o),
		.clk8m_en_o (clk8m_en_o)
	);

	pll_reconfig_seq pll_reconfig_seq_i (
		.clk_sys          (clk_sys),
		.arst_n_i         (arst_n_i),
		.pix_sel_i        (pix_sel_i),
		.pll_busy_i       (pll_busy_i),
		.pll_rom_bits_i   (pll_rom_bits_i),
		.pll_rom_q_o      (pll_rom_q_o),
		.write_from_rom_o (write_from_rom_o),
		.reconfig_o       (reconfig_o),
		.reconfig_reset_o (reconfig_reset_o),
		.vid_clk_ena_o    (vid_clk_ena_o)
	);

	// same select drives the mode decode for blanking
	porch_blanker porch_blanker_i (
		.clk_sys               (clk_sys),
		.arst_n_i              (arst_n_i),
		.ce_pix_i              (ce_pix_i),
		.pix_sel_i             (pix_sel_i),
		.scandoubler_disable_i (scandoubler_disable_i),
		.video_i               (video_i),
		.video_o               (video_o),
		.scandoubler_en_o      (scandoubler_en_o)
	);

	loader_bus_arbiter loader_bus_arbiter_i (
		.clk_sys        (clk_sys),
		.arst_n_i       (arst_n_i),
		.loader_i       (loader_i),
		.core_req_i     (core_req_i),
		.core_ack_o     (core_ack_o),
		.ram_req_o      (ram_req_o),
		.ram_ack_i      (ram_ack_i),
		.ram_ready_i    (ram_ready_i),
		.reset_button_i (reset_button_i),
		.rom_ready_o    (rom_ready_o),
		.core_reset_o   (core_reset_o)
	);

endmodule

// File: rtl/clk_enable_gen.sv
`timescale 1ns/1ps

module clk_enable_gen import archie_pkg::*; (
	input  logic clk_sys,
	input  logic arst_n_i,
	output logic clk2m_en_o,
	output logic clk8m_en_o
);

	logic [CLKEN_CNT_W-1:0] round_cnt;
	logic [CLK8M_CNT_W-1:0] step_cnt;

	// the step counter stays aligned since the round is a multiple of the step
	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			round_cnt  <= '0;
			step_cnt   <= '0;
			clk2m_en_o <= 1'b0;
			clk8m_en_o <= 1'b0;
		end else begin
			if (round_cnt == CLKEN_CNT_W'(CLKEN_PERIOD - 1))
				round_cnt <= '0;
			else
				round_cnt <= round_cnt + 1'b1;

			if (step_cnt == CLK8M_CNT_W'(CLK8M_STEP - 1))
				step_cnt <= '0;
			else
				step_cnt <= step_cnt + 1'b1;

			clk2m_en_o <= (round_cnt == '0);
			clk8m_en_o <= (step_cnt == '0);
		end
	end

endmodule

// File: rtl/loader_bus_arbiter.sv
`timescale 1ns/1ps

module loader_bus_arbiter import archie_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n_i,
	input  loader_wr_t loader_i,
	input  wb_req_t    core_req_i,
	output logic       core_ack_o,
	output wb_req_t    ram_req_o,
	input  logic       ram_ack_i,
	input  logic       ram_ready_i,
	input  logic       reset_button_i,
	output logic       rom_ready_o,
	output logic       core_reset_o
);

	logic                     loader_active;
	logic                     loader_active_q;
	logic                     loader_stb;
	logic [LOADER_ADDR_W-1:0] loader_addr_q;
	logic [7:0]               loader_data_q;
	logic [3:0]               loader_sel;
	wb_req_t                  loader_req;

	// only the rom images go to ram
	assign loader_active = loader_i.downloading &&
	                       (loader_i.index == LOADER_ROM_IDX1 ||
	                        loader_i.index == LOADER_ROM_IDX2);

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			loader_stb      <= 1'b0;
			loader_active_q <= 1'b0;
			rom_ready_o     <= 1'b0;
		end else begin
			loader_active_q <= loader_active;
			// end of download means the rom is in place
			if (loader_active_q && !loader_active)
				rom_ready_o <= 1'b1;

			if (loader_active && loader_i.wr)
				loader_stb <= 1'b1;
			else if (ram_ack_i)
				loader_stb <= 1'b0;
		end
	end

	// hold the byte and address for the whole bus cycle
	always_ff @(posedge clk_sys) begin
		if (loader_active && loader_i.wr) begin
			loader_addr_q <= loader_i.addr;
			loader_data_q <= loader_i.data;
		end
	end

	// byte lane from the low address bits
	assign loader_sel = 4'b0001 << loader_addr_q[1:0];

	assign loader_req.adr = {{(RAM_ADDR_W - LOADER_ADDR_W){1'b0}},
	                         loader_addr_q[LOADER_ADDR_W-1:2], 2'b00};
	assign loader_req.dat = {4{loader_data_q}};
	assign loader_req.sel = loader_sel;
	assign loader_req.we  = 1'b1;
	assign loader_req.stb = loader_stb;
	assign loader_req.cyc = loader_stb;

	assign ram_req_o  = loader_active ? loader_req : core_req_i;
	assign core_ack_o = loader_active ? 1'b0 : ram_ack_i;

	assign core_reset_o = !ram_ready_i || !rom_ready_o || reset_button_i;

endmodule

// File: rtl/pll_reconfig_seq.sv
`timescale 1ns/1ps

module pll_reconfig_seq import archie_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n_i,
	input  logic [1:0] pix_sel_i,
	input  logic       pll_busy_i,
	input  logic [2:0] pll_rom_bits_i,
	output logic       pll_rom_q_o,
	output logic       write_from_rom_o,
	output logic       reconfig_o,
	output logic       reconfig_reset_o,
	output logic       vid_clk_ena_o
);

	logic [1:0]            state;
	logic [1:0]            pix_sel_q;
	logic [RCFG_TMO_W-1:0] timeout;

	// rom image for the requested base clock, bit 0 is the 24 MHz image
	always_comb begin
		case (pix_sel_i)
			PIX_SEL_25: pll_rom_q_o = pll_rom_bits_i[1];
			PIX_SEL_36: pll_rom_q_o = pll_rom_bits_i[2];
			default:    pll_rom_q_o = pll_rom_bits_i[0];
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state            <= RCFG_IDLE;
			pix_sel_q        <= PIX_SEL_RESET;
			timeout          <= '0;
			write_from_rom_o <= 1'b0;
			reconfig_o       <= 1'b0;
			reconfig_reset_o <= 1'b0;
			vid_clk_ena_o    <= 1'b1;
		end else begin
			write_from_rom_o <= 1'b0;
			reconfig_o       <= 1'b0;
			reconfig_reset_o <= 1'b0;

			case (state)
				RCFG_IDLE: begin
					vid_clk_ena_o <= 1'b1;
					pix_sel_q     <= pix_sel_i;
					// base clock changed, stop video clocks and reload
					if (pix_sel_q != pix_sel_i) begin
						vid_clk_ena_o    <= 1'b0;
						write_from_rom_o <= 1'b1;
						state            <= RCFG_SETTLE;
					end
				end
				RCFG_SETTLE: begin
					state <= RCFG_START;
				end
				RCFG_START: begin
					if (!pll_busy_i) begin
						reconfig_o <= 1'b1;
						timeout    <= RECONFIG_TIMEOUT;
						state      <= RCFG_WAIT;
					end
				end
				RCFG_WAIT: begin
					timeout <= timeout - 1'b1;
					// reconfig block stuck busy
					if (timeout == RCFG_TMO_W'(1)) begin
						reconfig_reset_o <= 1'b1;
						state            <= RCFG_IDLE;
					end
					if (!reconfig_o && !pll_busy_i)
						state <= RCFG_IDLE;
				end
				default: state <= RCFG_IDLE;
			endcase
		end
	end

endmodule

// File: rtl/porch_blanker.sv
`timescale 1ns/1ps

module porch_blanker import archie_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n_i,
	input  logic      ce_pix_i,
	input  logic [1:0] pix_sel_i,
	input  logic      scandoubler_disable_i,
	input  video_px_t video_i,
	output video_px_t video_o,
	output logic      scandoubler_en_o
);

	logic [PORCH_CNT_W-1:0] porch_cnt;
	logic                   tv_mode;
	logic                   porch_done;

	// equal select bits mean a 15 kHz tv mode
	assign tv_mode = (pix_sel_i[0] == pix_sel_i[1]);

	assign porch_done = tv_mode ? (porch_cnt == PORCH_CNT_W'(PORCH_TV - 1)) :
	                              (porch_cnt[PORCH_VGA_W-1:0] == PORCH_VGA_W'(PORCH_VGA - 1));

	assign scandoubler_en_o = tv_mode && !scandoubler_disable_i;

	// saturating count from the rising edge of the registered hsync
	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i)
			porch_cnt <= '0;
		else if (!video_o.hsync)
			porch_cnt <= '0;
		else if (!porch_done)
			porch_cnt <= porch_cnt + 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (ce_pix_i) begin
			video_o.hsync <= video_i.hsync;
			video_o.vsync <= video_i.vsync;
			if (porch_done) begin
				video_o.red   <= video_i.red;
				video_o.green <= video_i.green;
				video_o.blue  <= video_i.blue;
			end else begin
				// black inside the back porch
				video_o.red   <= '0;
				video_o.green <= '0;
				video_o.blue  <= '0;
			end
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and scan the log for a failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_archie_support -f verilog.f \
	> build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_archie_support > sim.log 2>&1

grep -q "Something failed" sim.log \
	&& { echo "simulation failed, see sim.log"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

// File: testbench/tb_archie_support.sv
`timescale 1ns/1ps

module tb_archie_support import archie_pkg::*; ();

	logic       clk_sys;
	logic       arst_n_i;
	logic       clk2m_en_o;
	logic       clk8m_en_o;
	logic [1:0] pix_sel_i;
	logic       pll_busy_i;
	logic [2:0] pll_rom_bits_i;
	logic       pll_rom_q_o;
	logic       write_from_rom_o;
	logic       reconfig_o;
	logic       reconfig_reset_o;
	logic       vid_clk_ena_o;
	logic       ce_pix_i;
	logic       scandoubler_disable_i;
	video_px_t  video_i;
	video_px_t  video_o;
	logic       scandoubler_en_o;
	loader_wr_t loader_i;
	wb_req_t    core_req_i;
	logic       core_ack_o;
	wb_req_t    ram_req_o;
	logic       ram_ack_i;
	logic       ram_ready_i;
	logic       reset_button_i;
	logic       rom_ready_o;
	logic       core_reset_o;

	logic [15:0] lfsr_state;

	archie_support_top archie_support_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		abort_run();
	endtask

	task automatic check(input logic [95:0] actual, input logic [95:0] expected,
	                     input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
			         $time, what, actual, expected);
			abort_run();
		end
	endtask

	// cycles from one strobe to the next
	task automatic measure_gap(input bit slow, output int gap);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!(slow ? clk2m_en_o : clk8m_en_o)) begin
			@(negedge clk_sys);
			n++;
			if (n > 2 * CLKEN_PERIOD)
				report_timeout("a first enable strobe");
		end
		gap = 0;
		do begin
			@(negedge clk_sys);
			gap++;
			if (gap > 2 * CLKEN_PERIOD)
				report_timeout("the next enable strobe");
		end while (!(slow ? clk2m_en_o : clk8m_en_o));
	endtask

	task automatic clock_enable_spacing();
		int gap;
		measure_gap(1'b0, gap);
		check(gap, CLK8M_STEP, "8 MHz strobe spacing");
		measure_gap(1'b1, gap);
		check(gap, CLKEN_PERIOD, "2 MHz strobe spacing");
		for (int i = 0; i < 2 * CLKEN_PERIOD; i++) begin
			@(negedge clk_sys);
			if (clk2m_en_o)
				check(clk8m_en_o, 1'b1, "8 MHz strobe together with 2 MHz strobe");
		end
	endtask

	// counts pll pulses until the video clock comes back
	task automatic watch_reload(output int wr_cnt, output int rc_cnt, output int rr_cnt);
		int n;
		bit seen_low;
		n = 0;
		seen_low = 1'b0;
		wr_cnt = 0;
		rc_cnt = 0;
		rr_cnt = 0;
		@(negedge clk_sys);
		while (!(seen_low && vid_clk_ena_o)) begin
			if (!vid_clk_ena_o)
				seen_low = 1'b1;
			if (write_from_rom_o) begin
				wr_cnt++;
				check(vid_clk_ena_o, 1'b0, "video clock gated at rom write");
			end
			if (reconfig_o)
				rc_cnt++;
			if (reconfig_reset_o)
				rr_cnt++;
			@(negedge clk_sys);
			n++;
			if (n > 40)
				report_timeout("the video clock enable after a reload");
		end
	endtask

	task automatic pll_reload();
		int wr_cnt;
		int rc_cnt;
		int rr_cnt;
		logic [1:0] sel;
		logic [2:0] bits;
		logic exp_q;
		@(posedge clk_sys);
		pix_sel_i <= PIX_SEL_25;
		watch_reload(wr_cnt, rc_cnt, rr_cnt);
		check(wr_cnt, 1, "write_from_rom pulses");
		check(rc_cnt, 1, "reconfig pulses");
		check(rr_cnt, 0, "reconfig_reset pulses");
		// each step changes the select and forces a reload
		for (int s = 0; s < 4; s++) begin
			sel = 2'((s + 2) % 4);
			bits = 3'(rand_bits(3));
			@(posedge clk_sys);
			pix_sel_i <= sel;
			pll_rom_bits_i <= bits;
			@(negedge clk_sys);
			// codes without an own image fall back to the 24 MHz one
			if (sel == PIX_SEL_25)
				exp_q = bits[1];
			else if (sel == PIX_SEL_36)
				exp_q = bits[2];
			else
				exp_q = bits[0];
			check(pll_rom_q_o, exp_q, $sformatf("rom bit for select %0d", sel));
			watch_reload(wr_cnt, rc_cnt, rr_cnt);
			check(wr_cnt, 1, "write_from_rom pulses per reload");
			check(rc_cnt, 1, "reconfig pulses per reload");
			check(rr_cnt, 0, "reconfig_reset pulses per reload");
		end
	endtask

	task automatic stuck_pll_recovery();
		int n;
		@(posedge clk_sys);
		pix_sel_i <= PIX_SEL_24;
		n = 0;
		@(negedge clk_sys);
		while (!reconfig_o) begin
			@(negedge clk_sys);
			n++;
			if (n > 20)
				report_timeout("the reconfig pulse");
		end
		@(posedge clk_sys);
		pll_busy_i <= 1'b1;
		// n counts cycles since the reconfig pulse
		n = 1;
		@(negedge clk_sys);
		while (!reconfig_reset_o) begin
			@(negedge clk_sys);
			n++;
			if (n > RECONFIG_TIMEOUT + 10)
				report_timeout("the reconfig reset pulse");
		end
		check(n >= RECONFIG_TIMEOUT && n <= RECONFIG_TIMEOUT + 3, 1'b1,
		      $sformatf("reconfig reset after %0d cycles", n));
		@(posedge clk_sys);
		pll_busy_i <= 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (!vid_clk_ena_o) begin
			@(negedge clk_sys);
			n++;
			if (n > 10)
				report_timeout("the video clock enable after the reset");
		end
	endtask

	task automatic porch_window(input logic [1:0] sel, input int expected,
	                            input logic exp_sd_en);
		int n;
		video_px_t px;
		px.red = 4'(rand_bits(COLOR_W)) | 4'h1;
		px.green = 4'(rand_bits(COLOR_W)) | 4'h1;
		px.blue = 4'(rand_bits(COLOR_W)) | 4'h1;
		px.hsync = 1'b0;
		px.vsync = 1'b1;
		@(posedge clk_sys);
		pix_sel_i <= sel;
		video_i <= px;
		repeat (4) @(posedge clk_sys);
		px.hsync = 1'b1;
		video_i <= px;
		n = 0;
		@(negedge clk_sys);
		while (!video_o.hsync) begin
			@(negedge clk_sys);
			n++;
			if (n > 10)
				report_timeout("the registered hsync");
		end
		n = 0;
		while (video_o.red == '0 && video_o.green == '0 && video_o.blue == '0) begin
			@(negedge clk_sys);
			n++;
			if (n > PORCH_TV + 20)
				report_timeout("the end of the blanking window");
		end
		check(n >= expected - 2 && n <= expected + 2, 1'b1,
		      $sformatf("black window of %0d cycles for select %0d", n, sel));
		check(video_o, px, "video after the window");
		check(scandoubler_en_o, exp_sd_en, "scandoubler enable");
	endtask

	task automatic porch_blanking();
		porch_window(PIX_SEL_24, PORCH_TV, 1'b1);
		porch_window(PIX_SEL_25, PORCH_VGA, 1'b0);
		@(posedge clk_sys);
		scandoubler_disable_i <= 1'b1;
		porch_window(2'b11, PORCH_TV, 1'b0);
		porch_window(PIX_SEL_36, PORCH_VGA, 1'b0);
		@(posedge clk_sys);
		scandoubler_disable_i <= 1'b0;
	endtask

	task automatic rom_download();
		int n;
		int delay;
		logic [LOADER_ADDR_W-1:0] addr;
		logic [7:0] data;
		wb_req_t exp_req;
		@(posedge clk_sys);
		loader_i.downloading <= 1'b1;
		loader_i.index <= LOADER_ROM_IDX1;
		// cpu keeps asking while the loader owns the bus
		core_req_i.stb <= 1'b1;
		core_req_i.cyc <= 1'b1;
		for (int i = 0; i < 8; i++) begin
			addr = LOADER_ADDR_W'(rand_bits(LOADER_ADDR_W));
			data = 8'(rand_bits(8));
			delay = int'(rand_bits(2));
			@(posedge clk_sys);
			loader_i.wr <= 1'b1;
			loader_i.addr <= addr;
			loader_i.data <= data;
			@(posedge clk_sys);
			loader_i.wr <= 1'b0;
			n = 0;
			@(negedge clk_sys);
			while (!ram_req_o.stb) begin
				@(negedge clk_sys);
				n++;
				if (n > 10)
					report_timeout("the loader write strobe");
			end
			exp_req.adr = RAM_ADDR_W'(addr & ~24'h3);
			exp_req.dat = {data, data, data, data};
			exp_req.sel = '0;
			exp_req.sel[addr[1:0]] = 1'b1;
			exp_req.we = 1'b1;
			exp_req.stb = 1'b1;
			exp_req.cyc = 1'b1;
			check(ram_req_o, exp_req, "loader write request");
			check(core_reset_o, 1'b1, "core reset during download");
			for (int d = 0; d < delay; d++) begin
				@(negedge clk_sys);
				check(ram_req_o.stb, 1'b1, "stb held until ack");
			end
			@(posedge clk_sys);
			ram_ack_i <= 1'b1;
			@(negedge clk_sys);
			check(ram_req_o.stb, 1'b1, "stb in the ack cycle");
			check(core_ack_o, 1'b0, "core ack while loading");
			@(posedge clk_sys);
			ram_ack_i <= 1'b0;
			@(negedge clk_sys);
			check(ram_req_o.stb, 1'b0, "stb after ack");
		end
		@(posedge clk_sys);
		loader_i.downloading <= 1'b0;
		core_req_i <= '0;
		n = 0;
		@(negedge clk_sys);
		while (core_reset_o) begin
			@(negedge clk_sys);
			n++;
			if (n > 10)
				report_timeout("core reset release after the download");
		end
		check(rom_ready_o, 1'b1, "rom ready after the download");
	endtask

	task automatic cpu_passthrough();
		wb_req_t req;
		logic ack;
		for (int i = 0; i < 8; i++) begin
			req.adr = RAM_ADDR_W'(rand_bits(RAM_ADDR_W));
			req.dat = rand_bits(32);
			req.sel = 4'(rand_bits(4));
			req.we = 1'(rand_bits(1));
			req.stb = 1'b1;
			req.cyc = 1'b1;
			ack = 1'(rand_bits(1));
			@(posedge clk_sys);
			core_req_i <= req;
			ram_ack_i <= ack;
			@(negedge clk_sys);
			check(ram_req_o, req, "cpu request on the ram bus");
			check(core_ack_o, ack, "cpu ack from ram");
			check(core_reset_o, 1'b0, "core running");
		end
		@(posedge clk_sys);
		core_req_i <= '0;
		ram_ack_i <= 1'b0;
		reset_button_i <= 1'b1;
		@(negedge clk_sys);
		check(core_reset_o, 1'b1, "core reset with the button pressed");
		@(posedge clk_sys);
		reset_button_i <= 1'b0;
		@(negedge clk_sys);
		check(core_reset_o, 1'b0, "core reset after the button");
	endtask

	initial begin
		lfsr_state = 16'd4;
		arst_n_i = 1'b0;
		pix_sel_i = PIX_SEL_RESET;
		pll_busy_i = 1'b0;
		pll_rom_bits_i = '0;
		ce_pix_i = 1'b1;
		scandoubler_disable_i = 1'b0;
		video_i = '0;
		loader_i = '0;
		core_req_i = '0;
		ram_ack_i = 1'b0;
		ram_ready_i = 1'b1;
		reset_button_i = 1'b0;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		check({clk2m_en_o, clk8m_en_o, write_from_rom_o, reconfig_o, reconfig_reset_o},
		      5'b0, "strobes and pll pulses in reset");
		check({vid_clk_ena_o, ram_req_o.stb, ram_req_o.cyc, rom_ready_o, core_reset_o},
		      5'b10001, "control outputs in reset");
		@(posedge clk_sys);
		arst_n_i <= 1'b1;
		clock_enable_spacing();
		pll_reload();
		stuck_pll_recovery();
		porch_blanking();
		rom_download();
		cpu_passthrough();
		$display("Everything OK");
		$finish;
	end

endmodule

// File: verilog.f
rtl/archie_pkg.sv
rtl/clk_enable_gen.sv
rtl/pll_reconfig_seq.sv
rtl/porch_blanker.sv
rtl/loader_bus_arbiter.sv
rtl/archie_support_top.sv
testbench/tb_archie_support.sv
